//--- mini_pipe.f
src/pipe_pkg.sv
src/fetch.sv
src/decode.sv
src/execute.sv
src/forward_stall.sv
src/pipeline_top.sv
dv/tb_pipeline_top.sv

//--- Bender.yml
package:
  name: mini_pipe

sources:
  - src/pipe_pkg.sv
  - src/fetch.sv
  - src/decode.sv
  - src/execute.sv
  - src/forward_stall.sv
  - src/pipeline_top.sv
  - target: test
    files:
      - dv/tb_pipeline_top.sv

//--- dv/tb_pipeline_top.sv
// ==================================================
// Pipeline testbench
// Directed programs checked against an in-order ISA model
// ==================================================
`default_nettype none

module tb_pipeline_top
    import pipe_pkg::*;
();

    localparam logic [31:0] RESET_PC      = 32'h0000_0100;
    localparam int          STORE_TIMEOUT = 3000;
    localparam int          DRAIN_CYCLES  = 64;

    logic           clk      = 1'b0;
    logic           rst_n;
    logic           imem_ack = 1'b1;
    logic           dbus_ack = 1'b1;
    logic           imem_drop = 1'b0;
    logic           dbus_drop = 1'b0;
    type_if2mem_s   if2mem;
    type_mem2if_s   mem2if;
    type_lsu2dbus_s lsu2dbus;

    logic [31:0] imem [64];
    logic [31:0] exp_addr[$];
    logic [31:0] exp_data[$];
    logic [31:0] seen_addr[$];
    logic [31:0] seen_data[$];
    int          prog_len;
    int          errors = 0;
    int          checks = 0;
    int          seed = 67178;

    pipeline_top #(
        .RESET_PC (RESET_PC)
    ) uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .if2mem_o   (if2mem),
        .mem2if_i   (mem2if),
        .lsu2dbus_o (lsu2dbus),
        .dbus_ack_i (dbus_ack)
    );

    always #4 clk = ~clk;

    // Instruction memory answers in the same cycle, 64 words from RESET_PC
    assign mem2if = {imem_ack, imem[if2mem.addr[7:2]]};

    // One block draws both ack patterns so the sequence is fixed
    always @(posedge clk) begin
        imem_ack <= imem_drop ? (($random(seed) & 3) != 0) : 1'b1;
        dbus_ack <= dbus_drop ? (($random(seed) & 1) != 0) : 1'b1;
    end

    // Store monitor
    always @(negedge clk) begin
        if (!rst_n) begin
            seen_addr.delete();
            seen_data.delete();
        end else if (lsu2dbus.w_en && dbus_ack) begin
            seen_addr.push_back(lsu2dbus.addr);
            seen_data.push_back(lsu2dbus.wdata);
        end
    end

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // Unused words hold an unsupported opcode tagged with their index
    task automatic clear_program();
        int i;
        for (i = 0; i < 64; i++) begin
            imem[i] = {19'h0, 6'(i), 7'h7f};
        end
        prog_len = 0;
    endtask

    task automatic put_instr(input logic [31:0] ins);
        imem[prog_len] = ins;
        prog_len++;
    endtask

    // Sequential ISA model, runs until the jump-to-self
    task automatic compute_expected();
        logic [31:0] xr [32];
        logic [31:0] pc, ins, a, b, res, nxt, imm_i, off;
        logic        wr;
        logic        done;
        int          steps;
        int          i;
        exp_addr.delete();
        exp_data.delete();
        for (i = 0; i < 32; i++) begin
            xr[i] = '0;
        end
        pc    = RESET_PC;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 500) begin
            ins   = imem[pc[7:2]];
            a     = xr[ins[19:15]];
            b     = xr[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            wr    = 1'b0;
            res   = '0;
            nxt   = pc + 32'd4;
            case (ins[6:0])
                7'b0010011: begin
                    wr = 1'b1;
                    case (ins[14:12])
                        3'b000:  res = a + imm_i;
                        3'b100:  res = a ^ imm_i;
                        3'b110:  res = a | imm_i;
                        3'b111:  res = a & imm_i;
                        default: wr = 1'b0;
                    endcase
                end
                7'b0110011: begin
                    wr = 1'b1;
                    case ({ins[31:25], ins[14:12]})
                        10'b0000000_000: res = a + b;
                        10'b0100000_000: res = a - b;
                        10'b0000000_010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        10'b0000000_100: res = a ^ b;
                        10'b0000000_110: res = a | b;
                        10'b0000000_111: res = a & b;
                        default:         wr = 1'b0;
                    endcase
                end
                7'b0110111: begin
                    wr  = 1'b1;
                    res = {ins[31:12], 12'b0};
                end
                7'b0100011: begin
                    if (ins[14:12] == 3'b010) begin
                        exp_addr.push_back(a + {{20{ins[31]}}, ins[31:25], ins[11:7]});
                        exp_data.push_back(b);
                    end
                end
                7'b1100011: begin
                    off = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                    if ((ins[14:12] == 3'b000 && a == b) ||
                        (ins[14:12] == 3'b001 && a != b)) begin
                        nxt = pc + off;
                    end
                end
                7'b1101111: begin
                    off  = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                    done = (off == '0);
                    wr   = 1'b1;
                    res  = pc + 32'd4;
                    nxt  = pc + off;
                end
                default: ;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                xr[ins[11:7]] = res;
            end
            pc = nxt;
            steps++;
        end
    endtask

    task automatic hold_reset(input logic imem_rand, input logic dbus_rand);
        @(posedge clk);
        rst_n     <= 1'b0;
        imem_drop <= imem_rand;
        dbus_drop <= dbus_rand;
    endtask

    // Releases reset and checks the first cycle out of it
    task automatic release_reset();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        checks++;
        assert (if2mem.req && if2mem.addr == RESET_PC && !lsu2dbus.w_en) else begin
            errors++;
            $display("ERR %0t: after reset req=%b addr=%h w_en=%b, expected req=1 addr=%h w_en=0",
                     $time, if2mem.req, if2mem.addr, lsu2dbus.w_en, RESET_PC);
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    task automatic check_program(input string name);
        int cycles;
        int i;
        compute_expected();
        release_reset();
        cycles = 0;
        while (seen_addr.size() < exp_addr.size() && cycles < STORE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (seen_addr.size() < exp_addr.size()) begin
            errors++;
            $display("Timeout in %s test: only %0d of %0d stores completed",
                     name, seen_addr.size(), exp_addr.size());
            finish_run();
        end else begin
            // Keep the jump-to-self loop running to catch a late extra store
            cycles = 0;
            while (seen_addr.size() == exp_addr.size() && cycles < DRAIN_CYCLES) begin
                @(posedge clk);
                cycles++;
            end
            checks++;
            assert (seen_addr.size() == exp_addr.size()) else begin
                errors++;
                $display("ERR %0t: %s test completed %0d stores, expected %0d",
                         $time, name, seen_addr.size(), exp_addr.size());
            end
            for (i = 0; i < exp_addr.size(); i++) begin
                checks++;
                assert (seen_addr[i] == exp_addr[i] && seen_data[i] == exp_data[i]) else begin
                    errors++;
                    $display("ERR %0t: %s store %0d wrote %h to %h, expected %h to %h",
                             $time, name, i, seen_data[i], seen_addr[i],
                             exp_data[i], exp_addr[i]);
                end
            end
        end
    endtask

    task automatic load_chain_program();
        clear_program();
        put_instr(enc_i(3'b000, 5'd1, 5'd0, 12'd5));
        put_instr(enc_i(3'b000, 5'd2, 5'd1, 12'd3));
        put_instr(enc_r(7'h00, 3'b000, 5'd3, 5'd2, 5'd1));
        put_instr(enc_r(7'h20, 3'b000, 5'd4, 5'd3, 5'd2));
        put_instr(enc_r(7'h00, 3'b100, 5'd5, 5'd4, 5'd3));
        put_instr(enc_r(7'h00, 3'b010, 5'd6, 5'd4, 5'd3));
        put_instr(enc_lui(5'd7, 20'h12345));
        put_instr(enc_i(3'b110, 5'd7, 5'd7, 12'h678));
        put_instr(enc_i(3'b111, 5'd8, 5'd7, 12'h0f0));
        put_instr(enc_r(7'h00, 3'b110, 5'd9, 5'd8, 5'd6));
        // Store data one instruction behind its producer
        put_instr(enc_sw(5'd9, 5'd0, 12'h010));
        put_instr(enc_sw(5'd3, 5'd0, 12'h014));
        put_instr(enc_sw(5'd5, 5'd0, 12'h018));
        put_instr(enc_i(3'b000, 5'd10, 5'd0, -12'sd3));
        put_instr(enc_r(7'h00, 3'b010, 5'd11, 5'd10, 5'd1));
        put_instr(enc_r(7'h20, 3'b000, 5'd12, 5'd10, 5'd1));
        put_instr(enc_i(3'b000, 5'd13, 5'd0, 12'h200));
        put_instr(enc_sw(5'd12, 5'd13, -12'sd4));
        put_instr(enc_i(3'b100, 5'd14, 5'd12, -12'sd1));
        put_instr(enc_r(7'h00, 3'b111, 5'd15, 5'd14, 5'd11));
        put_instr(enc_sw(5'd7, 5'd0, 12'h020));
        put_instr(enc_sw(5'd15, 5'd0, 12'h024));
        put_instr(enc_sw(5'd11, 5'd0, 12'h028));
        put_instr(enc_jal(5'd0, 21'd0));
    endtask

    task automatic load_branch_program();
        clear_program();
        put_instr(enc_i(3'b000, 5'd1, 5'd0, 12'd7));
        put_instr(enc_i(3'b000, 5'd2, 5'd0, 12'd7));
        put_instr(enc_b(3'b000, 5'd1, 5'd2, 13'd12));
        put_instr(enc_sw(5'd1, 5'd0, 12'h010));
        put_instr(enc_sw(5'd2, 5'd0, 12'h014));
        put_instr(enc_b(3'b001, 5'd1, 5'd2, 13'd8));
        put_instr(enc_sw(5'd1, 5'd0, 12'h018));
        put_instr(enc_i(3'b000, 5'd3, 5'd0, 12'd1));
        put_instr(enc_b(3'b001, 5'd1, 5'd3, 13'd12));
        put_instr(enc_sw(5'd3, 5'd0, 12'h024));
        put_instr(enc_sw(5'd3, 5'd0, 12'h028));
        put_instr(enc_jal(5'd5, 21'd12));
        put_instr(enc_sw(5'd1, 5'd0, 12'h02c));
        put_instr(enc_sw(5'd1, 5'd0, 12'h030));
        // Link value of the JAL above
        put_instr(enc_sw(5'd5, 5'd0, 12'h01c));
        put_instr(enc_b(3'b000, 5'd1, 5'd3, 13'd8));
        put_instr(enc_sw(5'd3, 5'd0, 12'h020));
        put_instr(enc_jal(5'd0, 21'd0));
    endtask

    task automatic load_store_program();
        clear_program();
        put_instr(enc_i(3'b000, 5'd2, 5'd0, 12'h055));
        put_instr(enc_sw(5'd2, 5'd0, 12'h000));
        put_instr(enc_sw(5'd2, 5'd0, 12'h004));
        put_instr(enc_i(3'b000, 5'd2, 5'd2, 12'd1));
        put_instr(enc_sw(5'd2, 5'd0, 12'h008));
        put_instr(enc_i(3'b000, 5'd1, 5'd0, 12'd12));
        // Loop of three stores with a forwarded base
        put_instr(enc_sw(5'd1, 5'd1, 12'h040));
        put_instr(enc_i(3'b000, 5'd1, 5'd1, -12'sd4));
        put_instr(enc_b(3'b001, 5'd1, 5'd0, -13'sd8));
        put_instr(enc_sw(5'd1, 5'd0, 12'h050));
        put_instr(enc_jal(5'd0, 21'd0));
    endtask

    task automatic load_unsupported_program();
        clear_program();
        put_instr(enc_i(3'b000, 5'd1, 5'd0, 12'd9));
        put_instr(enc_i(3'b000, 5'd0, 5'd0, 12'd7));
        put_instr(enc_r(7'h00, 3'b000, 5'd2, 5'd0, 5'd1));
        put_instr(enc_sw(5'd0, 5'd0, 12'h030));
        put_instr(enc_i(3'b010, 5'd1, 5'd1, 12'd100));
        put_instr(enc_r(7'h00, 3'b001, 5'd1, 5'd1, 5'd1));
        put_instr(enc_r(7'h01, 3'b000, 5'd1, 5'd1, 5'd1));
        // Load word, byte store and AUIPC
        put_instr({12'h000, 5'd0, 3'b010, 5'd1, 7'b0000011});
        put_instr({7'h01, 5'd1, 5'd0, 3'b000, 5'h1c, 7'b0100011});
        put_instr({20'h00001, 5'd1, 7'b0010111});
        put_instr(enc_b(3'b100, 5'd1, 5'd0, 13'd8));
        put_instr(enc_sw(5'd1, 5'd0, 12'h034));
        put_instr(enc_lui(5'd0, 20'hfffff));
        put_instr(enc_sw(5'd0, 5'd0, 12'h038));
        put_instr(enc_sw(5'd2, 5'd0, 12'h040));
        put_instr(enc_jal(5'd0, 21'd0));
    endtask

    task automatic test_reset_state();
        hold_reset(1'b0, 1'b0);
        clear_program();
        put_instr(enc_jal(5'd0, 21'd0));
        check_program("reset");
    endtask

    task automatic test_alu_chains();
        hold_reset(1'b0, 1'b0);
        load_chain_program();
        check_program("alu chain");
    endtask

    task automatic test_branches();
        hold_reset(1'b0, 1'b0);
        load_branch_program();
        check_program("branch");
    endtask

    task automatic test_store_backpressure();
        hold_reset(1'b0, 1'b1);
        load_store_program();
        check_program("store backpressure");
    endtask

    task automatic test_imem_drops();
        hold_reset(1'b1, 1'b0);
        load_chain_program();
        check_program("imem drop chain");
        hold_reset(1'b1, 1'b0);
        load_branch_program();
        check_program("imem drop branch");
        hold_reset(1'b1, 1'b1);
        load_store_program();
        check_program("imem drop store");
    endtask

    task automatic test_unsupported_and_x0();
        hold_reset(1'b0, 1'b0);
        load_unsupported_program();
        check_program("unsupported and x0");
    endtask

    initial begin
        rst_n = 1'b0;
        clear_program();
        test_reset_state();
        test_alu_chains();
        test_branches();
        test_store_backpressure();
        test_imem_drops();
        test_unsupported_and_x0();
        finish_run();
    end

endmodule : tb_pipeline_top

`default_nettype wire

//--- src/pipeline_top.sv
// ==================================================
// Pipeline top
// Fetch, decode, execute and hazard unit
// ==================================================
`default_nettype none

module pipeline_top
    import pipe_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  wire             clk,
    input  wire             rst_n,
    output type_if2mem_s    if2mem_o,
    input  wire type_mem2if_s mem2if_i,
    output type_lsu2dbus_s  lsu2dbus_o,
    input  wire             dbus_ack_i
);

    type_if2id_s     if2id;
    type_id2exe_s    id2exe;
    type_exe2if_fb_s exe2if_fb;
    type_exe2fwd_s   exe2fwd;
    type_wrb_s       wrb;
    type_fwd2exe_s   fwd2exe;
    type_fwd2pipe_s  fwd2pipe;

    fetch #(
        .RESET_PC (RESET_PC)
    ) fetch_module (
        .clk         (clk),
        .rst_n       (rst_n),
        .if2mem_o    (if2mem_o),
        .mem2if_i    (mem2if_i),
        .if2id_o     (if2id),
        .exe2if_fb_i (exe2if_fb),
        .fwd2if_i    (fwd2pipe)
    );

    decode decode_module (
        .clk      (clk),
        .rst_n    (rst_n),
        .if2id_i  (if2id),
        .wrb_i    (wrb),
        .fwd2id_i (fwd2pipe),
        .id2exe_o (id2exe)
    );

    execute execute_module (
        .clk            (clk),
        .rst_n          (rst_n),
        .id2exe_i       (id2exe),
        .fwd2exe_i      (fwd2exe),
        .fwd2exe_pipe_i (fwd2pipe),
        .exe2fwd_o      (exe2fwd),
        .exe2if_fb_o    (exe2if_fb),
        .wrb_o          (wrb),
        .lsu2dbus_o     (lsu2dbus_o)
    );

    forward_stall forward_stall_module (
        .clk        (clk),
        .rst_n      (rst_n),
        .exe2fwd_i  (exe2fwd),
        .wrb_i      (wrb),
        .dbus_ack_i (dbus_ack_i),
        .fwd2exe_o  (fwd2exe),
        .fwd2pipe_o (fwd2pipe)
    );

endmodule : pipeline_top

`default_nettype wire

//--- src/forward_stall.sv
// ==================================================
// Hazard unit
// Forward selects, store stall and branch flush
// ==================================================
`default_nettype none

module forward_stall
    import pipe_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire type_exe2fwd_s exe2fwd_i,
    input  wire type_wrb_s     wrb_i,
    input  wire             dbus_ack_i,
    output type_fwd2exe_s   fwd2exe_o,
    output type_fwd2pipe_s  fwd2pipe_o
);

    logic wrb_live;

    // x0 results are never forwarded
    assign wrb_live = wrb_i.we && wrb_i.rd != 5'd0;

    assign fwd2exe_o.fwd_rs1 = wrb_live && wrb_i.rd == exe2fwd_i.rs1;
    assign fwd2exe_o.fwd_rs2 = wrb_live && wrb_i.rd == exe2fwd_i.rs2;

    // Store waiting on the data bus holds the front of the pipe
    assign fwd2pipe_o.stall = exe2fwd_i.store_pending && !dbus_ack_i;
    assign fwd2pipe_o.flush = exe2fwd_i.branch_taken;

    // A store and a taken branch cannot share the EXE stage
    assert property (@(posedge clk) disable iff (!rst_n)
        !(fwd2pipe_o.stall && fwd2pipe_o.flush));

endmodule : forward_stall

`default_nettype wire

//--- src/execute.sv
// ==================================================
// Execute stage
// ALU, branch resolution, stores and EXE/WRB
// ==================================================
`default_nettype none

module execute
    import pipe_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire type_id2exe_s   id2exe_i,
    input  wire type_fwd2exe_s  fwd2exe_i,
    input  wire type_fwd2pipe_s fwd2exe_pipe_i,
    output type_exe2fwd_s   exe2fwd_o,
    output type_exe2if_fb_s exe2if_fb_o,
    output type_wrb_s       wrb_o,
    output type_lsu2dbus_s  lsu2dbus_o
);

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_result;
    logic            branch_taken;
    type_wrb_s       wrb_q;

    // Distance-one operands come from EXE/WRB
    assign op_a = fwd2exe_i.fwd_rs1 ? wrb_q.data : id2exe_i.rs1_data;
    assign op_b = fwd2exe_i.fwd_rs2 ? wrb_q.data : id2exe_i.rs2_data;

    always_comb begin
        case (id2exe_i.alu_op)
            ALU_ADD:    alu_result = op_a + op_b;
            ALU_SUB:    alu_result = op_a - op_b;
            ALU_AND:    alu_result = op_a & op_b;
            ALU_OR:     alu_result = op_a | op_b;
            ALU_XOR:    alu_result = op_a ^ op_b;
            ALU_SLT:    alu_result = XLEN'($signed(op_a) < $signed(op_b));
            ALU_PASS_B: alu_result = op_b;
            default:    alu_result = '0;
        endcase
    end

    always_comb begin
        case (id2exe_i.branch)
            BR_EQ:   branch_taken = id2exe_i.valid && (op_a == op_b);
            BR_NE:   branch_taken = id2exe_i.valid && (op_a != op_b);
            BR_JAL:  branch_taken = id2exe_i.valid;
            default: branch_taken = 1'b0;
        endcase
    end

    assign exe2if_fb_o.target = id2exe_i.pc + id2exe_i.imm;

    // Store strobe stays up until the bus acks
    assign lsu2dbus_o.w_en  = id2exe_i.valid && id2exe_i.is_store;
    assign lsu2dbus_o.addr  = op_a + id2exe_i.imm;
    assign lsu2dbus_o.wdata = op_b;

    assign exe2fwd_o.rs1           = id2exe_i.rs1;
    assign exe2fwd_o.rs2           = id2exe_i.rs2;
    assign exe2fwd_o.store_pending = lsu2dbus_o.w_en;
    assign exe2fwd_o.branch_taken  = branch_taken;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wrb_q <= '0;
        end else if (fwd2exe_pipe_i.stall) begin
            wrb_q.we <= 1'b0;
        end else begin
            wrb_q.we   <= id2exe_i.valid && id2exe_i.rd_we;
            wrb_q.rd   <= id2exe_i.rd;
            wrb_q.data <= alu_result;
        end
    end

    assign wrb_o = wrb_q;

    // Back-pressure keeps the store request frozen
    assert property (@(posedge clk) disable iff (!rst_n)
        fwd2exe_pipe_i.stall |=> lsu2dbus_o.w_en && $stable(lsu2dbus_o.addr)
                                 && $stable(lsu2dbus_o.wdata));

endmodule : execute

`default_nettype wire

//--- src/decode.sv
// ==================================================
// Decode stage
// Decoder, register file and ID/EXE register
// ==================================================
`default_nettype none

module decode
    import pipe_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire type_if2id_s    if2id_i,
    input  wire type_wrb_s      wrb_i,
    input  wire type_fwd2pipe_s fwd2id_i,
    output type_id2exe_s    id2exe_o
);

    logic [XLEN-1:0] regs [32];
    type_opcode_e    opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [4:0]      rs1_idx;
    logic [4:0]      rs2_idx;
    logic [4:0]      rd_idx;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic            supported;
    logic            writes;
    type_id2exe_s    dec;
    type_id2exe_s    id2exe_q;

    assign instr   = if2id_i.instr;
    assign opcode  = type_opcode_e'(instr[6:0]);
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign rd_idx  = instr[11:7];
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];

    assign imm_i = {{21{instr[31]}}, instr[30:20]};
    assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // x0 reads zero, a write in this cycle is passed through
    function automatic logic [XLEN-1:0] rf_read(input logic [4:0] idx);
        logic [XLEN-1:0] val;
        val = regs[idx];
        if (idx == 5'd0) begin
            val = '0;
        end else if (wrb_i.we && wrb_i.rd == idx) begin
            val = wrb_i.data;
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (wrb_i.we && wrb_i.rd != 5'd0) begin
            regs[wrb_i.rd] <= wrb_i.data;
        end
    end

    // Immediate forms carry the operand in the rs2 data slot with rs2 cleared
    always_comb begin
        dec          = '0;
        dec.pc       = if2id_i.pc;
        dec.rd       = rd_idx;
        dec.rs1      = rs1_idx;
        dec.rs2      = rs2_idx;
        dec.rs1_data = rf_read(rs1_idx);
        dec.rs2_data = rf_read(rs2_idx);
        supported    = 1'b1;
        writes       = 1'b0;
        case (opcode)
            OP_IMM: begin
                writes       = 1'b1;
                dec.rs2      = '0;
                dec.rs2_data = imm_i;
                dec.imm      = imm_i;
                case (funct3)
                    3'b000:  dec.alu_op = ALU_ADD;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b111:  dec.alu_op = ALU_AND;
                    default: supported = 1'b0;
                endcase
            end
            OP: begin
                writes = 1'b1;
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000:  dec.alu_op = ALU_ADD;
                        3'b010:  dec.alu_op = ALU_SLT;
                        3'b100:  dec.alu_op = ALU_XOR;
                        3'b110:  dec.alu_op = ALU_OR;
                        3'b111:  dec.alu_op = ALU_AND;
                        default: supported = 1'b0;
                    endcase
                end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
                    dec.alu_op = ALU_SUB;
                end else begin
                    supported = 1'b0;
                end
            end
            LUI: begin
                writes       = 1'b1;
                dec.alu_op   = ALU_PASS_B;
                dec.rs1      = '0;
                dec.rs1_data = '0;
                dec.rs2      = '0;
                dec.rs2_data = imm_u;
                dec.imm      = imm_u;
            end
            STORE: begin
                dec.is_store = 1'b1;
                dec.imm      = imm_s;
                supported    = (funct3 == 3'b010);
            end
            BRANCH: begin
                dec.imm = imm_b;
                case (funct3)
                    3'b000:  dec.branch = BR_EQ;
                    3'b001:  dec.branch = BR_NE;
                    default: supported = 1'b0;
                endcase
            end
            JAL: begin
                writes       = 1'b1;
                dec.branch   = BR_JAL;
                dec.alu_op   = ALU_PASS_B;
                dec.rs1      = '0;
                dec.rs1_data = '0;
                dec.rs2      = '0;
                dec.rs2_data = if2id_i.pc + XLEN'(4);
                dec.imm      = imm_j;
            end
            default: supported = 1'b0;
        endcase
        dec.valid = if2id_i.valid && supported;
        dec.rd_we = writes && rd_idx != 5'd0;
        if (!dec.valid) begin
            dec.rd_we    = 1'b0;
            dec.is_store = 1'b0;
            dec.branch   = BR_NONE;
        end
    end

    // On stall the held entry still picks up the result leaving writeback
    always_ff @(posedge clk) begin
        if (!rst_n || fwd2id_i.flush) begin
            id2exe_q <= '0;
        end else if (fwd2id_i.stall) begin
            if (wrb_i.we && wrb_i.rd == id2exe_q.rs1) begin
                id2exe_q.rs1_data <= wrb_i.data;
            end
            if (wrb_i.we && wrb_i.rd == id2exe_q.rs2) begin
                id2exe_q.rs2_data <= wrb_i.data;
            end
        end else begin
            id2exe_q <= dec;
        end
    end

    assign id2exe_o = id2exe_q;

    // Execute must never request a write to x0
    assert property (@(posedge clk) disable iff (!rst_n) wrb_i.we |-> wrb_i.rd != 5'd0);

endmodule : decode

`default_nettype wire

//--- src/fetch.sv
// ==================================================
// Fetch stage
// PC, instruction request and IF/ID register
// ==================================================
`default_nettype none

module fetch
    import pipe_pkg::*;
#(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  wire             clk,
    input  wire             rst_n,
    output type_if2mem_s    if2mem_o,
    input  wire type_mem2if_s mem2if_i,
    output type_if2id_s     if2id_o,
    input  wire type_exe2if_fb_s exe2if_fb_i,
    input  wire type_fwd2pipe_s  fwd2if_i
);

    localparam type_if2id_s IF2ID_BUBBLE = '{instr: INSTR_NOP, pc: '0, valid: 1'b0};

    logic [XLEN-1:0] pc_q;
    type_if2id_s     if2id_q;

    // Request is up whenever the core is out of reset
    assign if2mem_o.req  = rst_n;
    assign if2mem_o.addr = pc_q;
    assign if2id_o       = if2id_q;

    // Flush beats stall, stall beats a missing ack
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q    <= RESET_PC;
            if2id_q <= IF2ID_BUBBLE;
        end else if (fwd2if_i.flush) begin
            pc_q    <= exe2if_fb_i.target;
            if2id_q <= IF2ID_BUBBLE;
        end else if (fwd2if_i.stall) begin
            pc_q    <= pc_q;
            if2id_q <= if2id_q;
        end else if (!mem2if_i.ack) begin
            if2id_q <= IF2ID_BUBBLE;
        end else begin
            pc_q    <= pc_q + XLEN'(4);
            if2id_q <= '{instr: mem2if_i.instr, pc: pc_q, valid: 1'b1};
        end
    end

    // Branch targets from execute must stay word aligned
    assert property (@(posedge clk) disable iff (!rst_n) pc_q[1:0] == 2'b00);

endmodule : fetch

`default_nettype wire

//--- src/pipe_pkg.sv
// ==================================================
// Pipeline package
// Opcodes, ALU ops and the stage-to-stage structs
// ==================================================
`default_nettype none

package pipe_pkg;

    localparam int XLEN = 32;

    // ADDI x0, x0, 0
    localparam logic [XLEN-1:0] INSTR_NOP = 32'h0000_0013;

    typedef enum logic [6:0] {
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } type_opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } type_alu_op_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_JAL
    } type_branch_e;

    // Instruction memory
    typedef struct packed {
        logic            req;
        logic [XLEN-1:0] addr;
    } type_if2mem_s;

    typedef struct packed {
        logic            ack;
        logic [XLEN-1:0] instr;
    } type_mem2if_s;

    // Data bus, stores only
    typedef struct packed {
        logic            w_en;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } type_lsu2dbus_s;

    typedef struct packed {
        logic [XLEN-1:0] instr;
        logic [XLEN-1:0] pc;
        logic            valid;
    } type_if2id_s;

    typedef struct packed {
        logic            valid;
        type_alu_op_e    alu_op;
        type_branch_e    branch;
        logic            is_store;
        logic            rd_we;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
        logic [XLEN-1:0] imm;
        logic [XLEN-1:0] pc;
    } type_id2exe_s;

    typedef struct packed {
        logic [XLEN-1:0] target;
    } type_exe2if_fb_s;

    typedef struct packed {
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic       store_pending;
        logic       branch_taken;
    } type_exe2fwd_s;

    // Register file write from EXE/WRB
    typedef struct packed {
        logic            we;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } type_wrb_s;

    typedef struct packed {
        logic fwd_rs1;
        logic fwd_rs2;
    } type_fwd2exe_s;

    typedef struct packed {
        logic stall;
        logic flush;
    } type_fwd2pipe_s;

endpackage : pipe_pkg

`default_nettype wire
